// ==== hw/vmask_pkg.sv ====
`default_nettype none

package vmask_pkg;

  // operation codes of the control word, codes 9 to 15 are reserved.
  typedef enum logic [3:0] {
    vmask_and   = 4'd0,  // vs2 and vs1.
    vmask_or    = 4'd1,  // vs2 or vs1.
    vmask_xor   = 4'd2,  // vs2 xor vs1.
    vmask_popc  = 4'd3,  // count of active set bits.
    vmask_first = 4'd4,  // index of the lowest active set bit.
    vmask_sbf   = 4'd5,  // set before first.
    vmask_sif   = 4'd6,  // set including first.
    vmask_sof   = 4'd7,  // set only first.
    vmask_iota  = 4'd8   // active set bits below the vs1 index.
  } vmask_op_e;

  // control word, laid out as bits 5 to 0 of the control register.
  typedef struct packed {
    logic      out_inv;  // bit 5 inverts the logical result.
    logic      in_inv;   // bit 4 inverts vs1 before a logical operation.
    vmask_op_e op;       // bits 3 to 0 select the operation.
  } vmask_ctrl_t;

  // the three source words that software loads before an operation.
  typedef struct packed {
    logic [31:0] vs1_data;   // first operand, also the iota index.
    logic [31:0] vs2_data;   // source mask of the operation.
    logic [31:0] mask_bits;  // active element mask.
  } vmask_operands_t;

  // element index inside one 32-bit mask word.
  typedef logic [4:0] vmask_idx_t;

  // byte offsets of the register map.
  parameter logic [7:0] reg_vs1    = 8'h00;
  parameter logic [7:0] reg_vs2    = 8'h04;
  parameter logic [7:0] reg_mask   = 8'h08;
  parameter logic [7:0] reg_ctrl   = 8'h0C;  // a write here starts an operation.
  parameter logic [7:0] reg_result = 8'h10;  // read only.
  parameter logic [7:0] reg_status = 8'h14;  // bit 0 is done, read only.

endpackage

`default_nettype wire

// ==== hw/mask_first_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mask_first_encoder (
  input  logic                 [31:0] src,
  input  logic                 [31:0] mask_bits,
  output logic                        found,
  output vmask_pkg::vmask_idx_t       index
);

  import vmask_pkg::*;

  logic [31:0] masked;  // source bits that lie on active elements.

  assign masked = src & mask_bits;
  assign found  = |masked;  // low when nothing survives the mask.

  // priority encoder, the scan runs from the top so the lowest hit wins.
  always_comb begin
    index = '0;
    for (int i = 31; i >= 0; i--) begin
      if (masked[i]) begin
        index = vmask_idx_t'(i);
      end
    end
  end

  // the reported position must point at a surviving bit of the source.
  always_comb begin
    if (found) begin
      assert (masked[index])
        else $error("first encoder index %0d does not hit a masked bit", index);
    end
  end

endmodule

`default_nettype wire

// ==== hw/mask_popcount.sv ====
`timescale 1ns/1ps
`default_nettype none

module mask_popcount (
  input  logic                 [31:0] src,
  input  logic                 [31:0] mask_bits,
  input  logic                        limit_en,
  input  vmask_pkg::vmask_idx_t       limit,
  output logic                 [5:0]  count
);

  import vmask_pkg::*;

  logic [31:0] limit_mask;  // positions that may be counted.
  logic [31:0] counted;     // active set bits inside the limit.
  logic [3:0]  part [4];    // one partial count per byte.

  // adder tree over one byte, pairs first, then quads, then the byte.
  function automatic logic [3:0] tree_add8(input logic [7:0] b);
    logic [1:0] p0, p1, p2, p3;
    logic [2:0] q0, q1;
    p0 = {1'b0, b[0]} + {1'b0, b[1]};
    p1 = {1'b0, b[2]} + {1'b0, b[3]};
    p2 = {1'b0, b[4]} + {1'b0, b[5]};
    p3 = {1'b0, b[6]} + {1'b0, b[7]};
    q0 = {1'b0, p0} + {1'b0, p1};
    q1 = {1'b0, p2} + {1'b0, p3};
    return {1'b0, q0} + {1'b0, q1};
  endfunction

  // a limit of zero leaves no position, which gives a count of zero.
  assign limit_mask = limit_en ? ((32'd1 << limit) - 32'd1) : '1;
  assign counted    = src & mask_bits & limit_mask;

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      part[b] = tree_add8(counted[8*b +: 8]);
    end
    count = {2'b00, part[0]} + {2'b00, part[1]} + {2'b00, part[2]} + {2'b00, part[3]};
  end

  // four bytes of at most eight bits each can never pass 32.
  always_comb begin
    assert (count <= 6'd32)
      else $error("popcount result %0d exceeds the word width", count);
  end

endmodule

`default_nettype wire

// ==== hw/mask_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mask_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  vmask_pkg::vmask_ctrl_t     ctrl,
  input  vmask_pkg::vmask_operands_t operands,
  output logic                [31:0] result
);

  import vmask_pkg::*;

  logic        [31:0] in1;        // vs1 after optional input inversion.
  logic        [31:0] logic_res;  // raw result of the selected logical.
  logic        [31:0] logic_out;  // logical result after output inversion.
  logic               found;      // an active set bit exists in vs2.
  vmask_idx_t         first_idx;  // position of the lowest active set bit.
  logic        [5:0]  count;      // popcount or iota count.
  logic        [31:0] below;      // bits strictly below the first hit.
  logic        [31:0] only;       // the first hit on its own.
  logic               is_iota;

  assign in1     = ctrl.in_inv ? ~operands.vs1_data : operands.vs1_data;
  assign is_iota = (ctrl.op == vmask_iota);  // the counter limits itself only for iota.

  mask_first_encoder i_first (
    .src       (operands.vs2_data),
    .mask_bits (operands.mask_bits),
    .found     (found),
    .index     (first_idx)
  );

  // one counter serves both popc and iota with the index taken from vs1.
  mask_popcount i_popc (
    .src       (operands.vs2_data),
    .mask_bits (operands.mask_bits),
    .limit_en  (is_iota),
    .limit     (operands.vs1_data[4:0]),
    .count     (count)
  );

  always_comb begin
    case (ctrl.op)
      vmask_or:  logic_res = operands.vs2_data | in1;
      vmask_xor: logic_res = operands.vs2_data ^ in1;
      default:   logic_res = operands.vs2_data & in1;  // and is the default logical.
    endcase
  end

  assign logic_out = ctrl.out_inv ? ~logic_res : logic_res;
  assign only      = 32'd1 << first_idx;
  assign below     = only - 32'd1;  // all ones under the first hit.

  // the final selection handles every case without an active bit through found.
  always_comb begin
    case (ctrl.op)
      vmask_and,
      vmask_or,
      vmask_xor:   result = logic_out;
      vmask_popc,
      vmask_iota:  result = {26'd0, count};
      vmask_first: result = found ? {27'd0, first_idx} : '1;  // minus one when empty.
      vmask_sbf:   result = found ? below : '1;
      vmask_sif:   result = found ? (below | only) : '1;
      vmask_sof:   result = found ? only : '0;
      default:     result = '0;  // reserved codes give zero.
    endcase
  end

  // encoder and counter see the same active bits when no limit applies, so they agree on empty.
  assert property (@(posedge clk) disable iff (!rst_n)
    !is_iota |-> (found == (count != 6'd0)))
    else $error("popcount %0d disagrees with encoder found %0b", count, found);

endmodule

`default_nettype wire

// ==== hw/mask_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module mask_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic                [7:0]  adr,
  input  logic                [31:0] wdat,
  output logic                [31:0] rdat,
  output logic                       ack,
  output vmask_pkg::vmask_operands_t operands,
  output vmask_pkg::vmask_ctrl_t     ctrl,
  input  logic                [31:0] result
);

  import vmask_pkg::*;

  logic        req;       // a new transfer seen on this cycle.
  logic        wr_en;     // write strobe, valid on the edge that raises ack.
  logic        rd_en;     // read strobe, valid on the edge that raises ack.
  logic        ctrl_wr;   // a write that starts an operation.
  logic        pending;   // result is due on the next edge.
  logic        done;      // result register holds the latest operation.
  logic [31:0] result_q;  // captured output of the mask unit.
  logic [31:0] rd_mux;    // read data selected by the offset.

  // ack is blocked on the cycle after it rises, so each transfer takes two.
  assign req     = cyc && stb && !ack;
  assign wr_en   = req && we;
  assign rd_en   = req && !we;
  assign ctrl_wr = wr_en && (adr == reg_ctrl);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= req;  // one cycle after cyc and stb are first seen.
    end
  end

  // operand and control words load together with the write ack.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      operands <= '0;
      ctrl     <= '0;
    end else if (wr_en) begin
      case (adr)
        reg_vs1:  operands.vs1_data  <= wdat;
        reg_vs2:  operands.vs2_data  <= wdat;
        reg_mask: operands.mask_bits <= wdat;
        reg_ctrl: ctrl               <= vmask_ctrl_t'(wdat[5:0]);
        default:  ;  // unmapped and read-only offsets drop the write.
      endcase
    end
  end

  // the unit sees the new control word one edge before its result is taken.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending  <= 1'b0;
      done     <= 1'b0;
      result_q <= '0;
    end else if (ctrl_wr) begin
      pending <= 1'b1;
      done    <= 1'b0;  // the old result is no longer current.
    end else if (pending) begin
      pending  <= 1'b0;
      done     <= 1'b1;
      result_q <= result;
    end
  end

  always_comb begin
    case (adr)
      reg_vs1:    rd_mux = operands.vs1_data;
      reg_vs2:    rd_mux = operands.vs2_data;
      reg_mask:   rd_mux = operands.mask_bits;
      reg_ctrl:   rd_mux = {26'd0, ctrl};
      reg_result: rd_mux = result_q;
      reg_status: rd_mux = {31'd0, done};
      default:    rd_mux = '0;  // unmapped offsets read as zero.
    endcase
  end

  // read data is registered so it is stable for the whole ack cycle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdat <= '0;
    end else if (rd_en) begin
      rdat <= rd_mux;
    end
  end

  // classic handshake, ack is a single pulse.
  assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
    else $error("ack held for two cycles");

  // the master keeps its request up until ack, so ack never shows alone.
  assert property (@(posedge clk) disable iff (!rst_n) ack |-> (cyc && stb))
    else $error("ack raised without cyc and stb");

endmodule

`default_nettype wire

// ==== hw/vmask_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmask_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cyc,   // wishbone cycle.
  input  logic        stb,   // wishbone strobe.
  input  logic        we,    // high for a write.
  input  logic [7:0]  adr,   // byte offset into the register map.
  input  logic [31:0] wdat,
  output logic [31:0] rdat,
  output logic        ack
);

  import vmask_pkg::*;

  vmask_operands_t operands;  // vs1, vs2 and mask from the registers.
  vmask_ctrl_t     ctrl;      // operation and inversion flags.
  logic [31:0]     result;    // combinational result of the unit.

  mask_regs i_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .wdat     (wdat),
    .rdat     (rdat),
    .ack      (ack),
    .operands (operands),
    .ctrl     (ctrl),
    .result   (result)
  );

  mask_unit i_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .operands (operands),
    .result   (result)
  );

endmodule

`default_nettype wire

// ==== test/tb_vmask_model.svh ====
`ifndef TB_VMASK_MODEL_SVH
`define TB_VMASK_MODEL_SVH

// expected result of one operation, built bit by bit from the operation rules.
function automatic logic [31:0] expected_result(input logic [3:0] op, input logic in_inv,
                                                input logic out_inv, input logic [31:0] vs1,
                                                input logic [31:0] vs2, input logic [31:0] mask);
  logic [31:0] src1;    // vs1 as the logical operations see it.
  logic [31:0] active;  // set bits of vs2 on active elements.
  logic [31:0] res;
  logic [31:0] sbf;
  logic [31:0] sif;
  logic [31:0] sof;
  int          first;   // position of the lowest active set bit, 32 when none.
  int          total;
  int          below;   // active set bits under the iota index.
  src1   = in_inv ? ~vs1 : vs1;
  active = vs2 & mask;
  first  = 32;
  total  = 0;
  below  = 0;
  for (int i = 0; i < 32; i++) begin
    if (active[i]) begin
      total++;
      if (first == 32) first = i;
      if (i < int'(vs1[4:0])) below++;
    end
  end
  // with no active bit first is 32, so sbf and sif fill the word and sof stays empty.
  for (int i = 0; i < 32; i++) begin
    sbf[i] = (i < first);
    sif[i] = (i <= first);
    sof[i] = (i == first);
  end
  case (op)
    vmask_and:   res = out_inv ? ~(vs2 & src1) : (vs2 & src1);
    vmask_or:    res = out_inv ? ~(vs2 | src1) : (vs2 | src1);
    vmask_xor:   res = out_inv ? ~(vs2 ^ src1) : (vs2 ^ src1);
    vmask_popc:  res = total;
    vmask_first: res = (first == 32) ? 32'hFFFF_FFFF : first;
    vmask_sbf:   res = sbf;
    vmask_sif:   res = sif;
    vmask_sof:   res = sof;
    vmask_iota:  res = below;
    default:     res = 32'd0;  // reserved codes.
  endcase
  return res;
endfunction

`endif

// ==== test/tb_vmask.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vmask;

  import vmask_pkg::*;

  `include "tb_vmask_model.svh"

  localparam int cycle_limit = 40000;  // about 2000 transfers of three cycles with a sixfold margin.

  logic        clk = 1'b0;
  logic        rst_n;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [7:0]  adr;
  logic [31:0] wdat;
  logic [31:0] rdat;
  logic        ack;

  logic [31:0] seed = 32'd16;  // lcg state.
  logic [31:0] vs1_q;          // operand copies for the model.
  logic [31:0] vs2_q;
  logic [31:0] mask_q;
  logic [31:0] last_result;    // result read by the latest run_op.
  int          cycles = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          checks_passed = 0;
  int          checks_failed = 0;
  vmask_op_e   logic_ops [3] = '{vmask_and, vmask_or, vmask_xor};

  vmask_top i_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .wdat  (wdat),
    .rdat  (rdat),
    .ack   (ack)
  );

  always #2 clk = ~clk;  // 4 ns period.

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("simulation timed out after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // one classic transfer with outputs sampled on the falling edge away from the drive edge.
  task automatic bus_transfer(input logic is_write, input logic [7:0] offset,
                              input logic [31:0] data, output logic [31:0] rd);
    @(posedge clk);
    cyc  <= 1'b1;
    stb  <= 1'b1;
    we   <= is_write;
    adr  <= offset;
    wdat <= data;
    do begin
      @(negedge clk);
    end while (ack !== 1'b1);
    rd = rdat;
    @(posedge clk);
    cyc <= 1'b0;  // request drops on the edge that ends the ack.
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) begin
      checks_passed++;
    end else begin
      $display("Error at %0t ns: rdat (%s) is 0x%08h, expected 0x%08h", $time, name, got, exp);
      checks_failed++;
      test_errors++;
    end
  endtask

  task automatic write_reg(input logic [7:0] offset, input logic [31:0] data);
    logic [31:0] unused_rd;
    bus_transfer(1'b1, offset, data, unused_rd);
  endtask

  task automatic read_check(input logic [7:0] offset, input string name,
                            input logic [31:0] exp);
    logic [31:0] got;
    bus_transfer(1'b0, offset, 32'd0, got);
    last_result = got;
    check_value(name, got, exp);
  endtask

  task automatic load_operands(input logic [31:0] v1, input logic [31:0] v2,
                               input logic [31:0] m);
    vs1_q  = v1;
    vs2_q  = v2;
    mask_q = m;
    write_reg(reg_vs1, v1);
    write_reg(reg_vs2, v2);
    write_reg(reg_mask, m);
  endtask

  // starts one operation, then checks done and the captured result.
  task automatic run_op(input logic [3:0] op, input logic in_inv, input logic out_inv);
    write_reg(reg_ctrl, {26'd0, out_inv, in_inv, op});
    read_check(reg_status, "status", 32'd1);
    read_check(reg_result, "result",
               expected_result(op, in_inv, out_inv, vs1_q, vs2_q, mask_q));
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("%-14s finished with %0d mismatches", name, test_errors);
    test_errors = 0;
  endtask

  initial begin
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] held;
    logic [1:0]  inv;
    rst_n <= 1'b0;
    cyc   <= 1'b0;
    stb   <= 1'b0;
    we    <= 1'b0;
    adr   <= 8'd0;
    wdat  <= 32'd0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    read_check(reg_result, "result", 32'd0);  // everything is zero out of reset.
    read_check(reg_status, "status", 32'd0);
    read_check(8'h18, "unmapped", 32'd0);
    finish_test("reset");

    for (int k = 0; k < 64; k++) begin
      inv = 2'((k / 3) % 4);  // walks the four inversion combinations.
      load_operands(next_rand(), next_rand(), next_rand());
      run_op(logic_ops[k % 3], inv[0], inv[1]);
    end
    finish_test("logicals");

    for (int k = 0; k < 64; k++) begin
      if (k == 0) load_operands(next_rand(), next_rand(), 32'd0);
      else if (k == 1) load_operands(next_rand(), 32'hFFFF_FFFF, 32'hFFFF_FFFF);
      else load_operands(next_rand(), next_rand(), next_rand());
      run_op(vmask_popc, 1'b0, 1'b0);
      if (k == 0) check_value("popc zero mask", last_result, 32'd0);
      if (k == 1) check_value("popc all ones", last_result, 32'd32);
      run_op(vmask_iota, 1'b0, 1'b0);  // index from vs1 bits 4 to 0.
    end
    finish_test("popc and iota");

    for (int k = 0; k < 64; k++) begin
      r0 = next_rand();
      r1 = next_rand();
      r2 = next_rand();
      if (k == 0) load_operands(r0, r1, 32'd0);  // no active bit at all.
      else if (k == 1) load_operands(r0, 32'd1, 32'hFFFF_FFFF);
      else load_operands(r0, r1 & r2 & (32'hFFFF_FFFF << r0[4:0]), r1 | r2);
      run_op(vmask_first, 1'b0, 1'b0);
      if (k == 0) check_value("first none", last_result, 32'hFFFF_FFFF);
      if (k == 1) check_value("first bit 0", last_result, 32'd0);
      run_op(vmask_sbf, 1'b0, 1'b0);
      run_op(vmask_sif, 1'b0, 1'b0);
      run_op(vmask_sof, 1'b0, 1'b0);
      if (k == 0) check_value("sof none", last_result, 32'd0);
    end
    finish_test("first and sets");

    load_operands(next_rand(), 32'hFFFF_FFFF, next_rand());
    for (int op = 9; op < 16; op++) begin
      run_op(4'(op), 1'b0, 1'b0);  // reserved codes read back zero.
      check_value("reserved op", last_result, 32'd0);
    end
    run_op(vmask_popc, 1'b0, 1'b0);
    held = expected_result(vmask_popc, 1'b0, 1'b0, vs1_q, vs2_q, mask_q);
    load_operands(next_rand(), next_rand(), next_rand());
    read_check(reg_result, "held result", held);  // no new control write yet.
    run_op(vmask_popc, 1'b0, 1'b0);
    finish_test("status and hold");

    $display("tests: %0d run, %0d with mismatches; checks: %0d passed, %0d failed",
             tests_run, tests_failed, checks_passed, checks_failed);
    if (checks_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+test
hw/vmask_pkg.sv
hw/mask_first_encoder.sv
hw/mask_popcount.sv
hw/mask_unit.sv
hw/mask_regs.sv
hw/vmask_top.sv
test/tb_vmask.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the vector mask testbench with verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_vmask -f project.f -o tb_vmask \
  > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/tb_vmask > sim.log 2>&1
cat sim.log
grep -qx "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
